/* verilog.f */
router_pkg.sv
flit_fifo.sv
input_port.sv
switch_allocator.sv
output_crossbar.sv
mesh_router.sv
mesh_router_sva.sv
tb_mesh_router.sv

/* run_sim.sh */
#!/bin/bash
# build and run the mesh router testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_mesh_router \
	-f verilog.f -o tb_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log

grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || { echo "no pass line in log"; exit 1; }
exit 0

/* tb_mesh_router.sv */
// ####################################################################
// mesh router testbench
// drives packets into the router at (1,1), checks each output flit
// against expected queues filled from an XY routing model
// ####################################################################
`timescale 1ns/100ps

module tb_mesh_router import router_pkg::*; ();

	logic      Clk;
	logic      Rst;
	flit_t     in_flit [NUM_PORTS];
	vc_t       in_vc [NUM_PORTS];
	flit_t     out_flit [NUM_PORTS];
	vc_t       out_vc [NUM_PORTS];
	flit_t     exp_q [NUM_PORTS][NUM_PORTS][NUM_VCS][$];  // output, source, vc
	int        pend [NUM_PORTS][NUM_VCS];                 // flits still in flight
	logic      pkt_open [NUM_PORTS];   // output is between a head and its tail
	int        pkt_src [NUM_PORTS];
	int        pkt_vc [NUM_PORTS];
	logic [31:0] lfsr;
	logic      hung;                   // a wait ran out of time
	int        errors;
	int        tests_run;
	int        tests_failed;

	mesh_router i_dut (
		.Clk          (Clk),
		.Rst          (Rst),
		.i_flit_local (in_flit[PORT_LOCAL]),
		.i_flit_north (in_flit[PORT_NORTH]),
		.i_flit_south (in_flit[PORT_SOUTH]),
		.i_flit_east  (in_flit[PORT_EAST]),
		.i_flit_west  (in_flit[PORT_WEST]),
		.i_vc_local   (in_vc[PORT_LOCAL]),
		.i_vc_north   (in_vc[PORT_NORTH]),
		.i_vc_south   (in_vc[PORT_SOUTH]),
		.i_vc_east    (in_vc[PORT_EAST]),
		.i_vc_west    (in_vc[PORT_WEST]),
		.i_addr_x     (3'd1),
		.i_addr_y     (3'd1),
		.o_flit_local (out_flit[PORT_LOCAL]),
		.o_flit_north (out_flit[PORT_NORTH]),
		.o_flit_south (out_flit[PORT_SOUTH]),
		.o_flit_east  (out_flit[PORT_EAST]),
		.o_flit_west  (out_flit[PORT_WEST]),
		.o_vc_local   (out_vc[PORT_LOCAL]),
		.o_vc_north   (out_vc[PORT_NORTH]),
		.o_vc_south   (out_vc[PORT_SOUTH]),
		.o_vc_east    (out_vc[PORT_EAST]),
		.o_vc_west    (out_vc[PORT_WEST])
	);

	always #10 Clk = ~Clk;

	// expected output port with x resolved before y
	function automatic int route_ref(int dx, int dy, int ax, int ay);
		if (dx > ax)
			return PORT_EAST;
		if (dx < ax)
			return PORT_WEST;
		if (dy > ay)
			return PORT_NORTH;
		if (dy < ay)
			return PORT_SOUTH;
		return PORT_LOCAL;
	endfunction

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'hA3000000;
		return b;
	endfunction

	function automatic int rand_bits(int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++)
			r = (r << 1) | int'(lfsr_bit());
		return r;
	endfunction

	task automatic send_packet(int p, int vc, int dx, int dy, int len);
		flit_t f;
		int    o;
		int    t;
		t = 0;
		while (!hung && pend[p][vc] + len > BUFF_DEPTH)   // keep the FIFO from overflowing
		begin
			@(posedge Clk);
			t++;
			if (t > 2000 && pend[p][vc] + len > BUFF_DEPTH)
			begin
				$display("timeout: input %0d vc %0d never drained", p, vc);
				errors++;
				hung = 1'b1;
			end
		end
		if (!hung)
		begin
			o = route_ref(dx, dy, 1, 1);
			pend[p][vc] += len;
			for (int i = 0; i < len; i++)
			begin
				f.payload = {3'(p), 1'(vc)};   // tag with source and vc
				f.dst_x   = coord_t'(dx);
				f.dst_y   = coord_t'(dy);
				f.kind    = (i == 0) ? FLIT_HEAD : (i == len - 1) ? FLIT_TAIL : FLIT_BODY;
				exp_q[o][p][vc].push_back(f);
				@(posedge Clk);
				in_flit[p] <= f;
				in_vc[p]   <= vc_t'(vc);
			end
			@(posedge Clk);
			in_flit[p] <= IDLE_FLIT;
		end
	endtask

	task automatic wait_drained();
		int t;
		int busy;
		t = 0;
		busy = 1;
		while (busy != 0 && !hung)
		begin
			@(posedge Clk);
			busy = 0;
			for (int p = 0; p < NUM_PORTS; p++)
				for (int v = 0; v < NUM_VCS; v++)
					busy += pend[p][v];
			t++;
			if (busy != 0 && t > 5000)
			begin
				$display("timeout: expected flits never left the router");
				errors++;
				hung = 1'b1;
			end
		end
		repeat (4) @(posedge Clk);
	endtask

	task automatic random_traffic(int p, int npkt);
		int gap;
		for (int k = 0; k < npkt; k++)
		begin
			send_packet(p, rand_bits(1), rand_bits(2) % 3, rand_bits(2) % 3,
				2 + rand_bits(2) % 3);
			gap = rand_bits(2);
			repeat (gap) @(posedge Clk);
		end
	endtask

	task automatic end_test(string name, int err_before);
		tests_run++;
		if (errors != err_before)
		begin
			tests_failed++;
			$display("test %s: FAIL with %0d errors", name, errors - err_before);
		end
		else
			$display("test %s: ok", name);
	endtask

	// scoreboard samples outputs at the falling edge
	always @(negedge Clk)
	begin : compare
		flit_t f;
		flit_t e;
		int    s;
		int    v;
		if (!Rst)
		begin
			for (int o = 0; o < NUM_PORTS; o++)
				pkt_open[o] = 1'b0;
		end
		else
		begin
			for (int o = 0; o < NUM_PORTS; o++)
			begin
				f = out_flit[o];
				if (f.kind != FLIT_IDLE)
				begin
					s = int'(f.payload[3:1]);
					v = int'(f.payload[0]);
					if (s >= NUM_PORTS)
					begin
						$display("output %0d carried a flit with a bad source tag", o);
						errors++;
					end
					else
					begin
						// one whole packet at a time on each output
						if (f.kind == FLIT_HEAD)
						begin
							if (pkt_open[o])
							begin
								$display("output %0d began a packet inside another", o);
								errors++;
							end
							pkt_open[o] = 1'b1;
							pkt_src[o]  = s;
							pkt_vc[o]   = v;
						end
						else if (!pkt_open[o] || pkt_src[o] != s || pkt_vc[o] != v)
						begin
							$display("output %0d mixed in a flit of source %0d vc %0d",
								o, s, v);
							errors++;
						end
						if (f.kind == FLIT_TAIL)
							pkt_open[o] = 1'b0;

						if (exp_q[o][s][v].size() == 0)
						begin
							$display("unexpected flit %h on output %0d from source %0d",
								f, o, s);
							errors++;
						end
						else
						begin
							e = exp_q[o][s][v].pop_front();
							pend[s][v]--;
							if (f !== e)
							begin
								$display("error at %0t: o_flit[%0d] expected %h got %h",
									$time, o, e, f);
								errors++;
							end
							if (out_vc[o] !== vc_t'(v))
							begin
								$display("error at %0t: o_vc[%0d] expected %0d got %0d",
									$time, o, v, out_vc[o]);
								errors++;
							end
						end
					end
				end
			end
		end
	end

	initial
	begin
		int e0;
		int left;
		Clk = 1'b0;
		Rst = 1'b0;
		lfsr = 32'd90543;
		hung = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			in_flit[p] = IDLE_FLIT;
			in_vc[p]   = '0;
			for (int v = 0; v < NUM_VCS; v++)
				pend[p][v] = 0;
		end
		repeat (5) @(posedge Clk);
		Rst <= 1'b1;

		e0 = errors;   // the monitor flags anything that shows up on idle outputs
		repeat (20) @(posedge Clk);
		end_test("idle_after_reset", e0);

		e0 = errors;
		send_packet(PORT_LOCAL, 0, 2, 1, 3);
		send_packet(PORT_LOCAL, 1, 0, 1, 2);
		send_packet(PORT_LOCAL, 0, 1, 2, 4);
		send_packet(PORT_LOCAL, 1, 1, 0, 3);
		send_packet(PORT_LOCAL, 0, 1, 1, 2);
		wait_drained();
		end_test("single_packets", e0);

		e0 = errors;
		send_packet(PORT_NORTH, 0, 2, 2, 4);
		send_packet(PORT_NORTH, 1, 0, 0, 3);
		wait_drained();
		end_test("two_vcs_one_input", e0);

		e0 = errors;
		fork
			begin
				send_packet(PORT_NORTH, 0, 1, 1, 4);
				send_packet(PORT_NORTH, 1, 1, 1, 3);
			end
			begin
				send_packet(PORT_SOUTH, 1, 1, 1, 3);
				send_packet(PORT_SOUTH, 0, 1, 1, 2);
			end
			send_packet(PORT_EAST, 0, 1, 1, 4);
			send_packet(PORT_WEST, 1, 1, 1, 4);
		join
		wait_drained();
		end_test("contention", e0);

		e0 = errors;
		fork
			random_traffic(PORT_LOCAL, 12);
			random_traffic(PORT_NORTH, 12);
			random_traffic(PORT_SOUTH, 12);
			random_traffic(PORT_EAST, 12);
			random_traffic(PORT_WEST, 12);
		join
		wait_drained();
		left = 0;
		for (int o = 0; o < NUM_PORTS; o++)
			for (int p = 0; p < NUM_PORTS; p++)
				for (int v = 0; v < NUM_VCS; v++)
					left += exp_q[o][p][v].size();
		if (left != 0)
		begin
			$display("%0d expected flits were never seen", left);
			errors++;
		end
		end_test("random_traffic", e0);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* mesh_router_sva.sv */
// ####################################################################
// mesh router assertions
// idle outputs in reset, whole packets per output, single grants
// ####################################################################
`timescale 1ns/100ps

module mesh_router_sva import router_pkg::*; (
	input logic                     Clk,
	input logic                     Rst,
	input flit_t [NUM_PORTS-1:0]    i_out,
	input port_vec_t [NUM_REQS-1:0] i_req,
	input req_vec_t                 i_grant
);

	port_vec_t open_q;   // output is inside a packet

	always_ff @(posedge Clk or negedge Rst)
	begin
		if (!Rst)
			open_q <= '0;
		else
			for (int o = 0; o < NUM_PORTS; o++)
				if (i_out[o].kind == FLIT_HEAD)
					open_q[o] <= 1'b1;
				else if (i_out[o].kind == FLIT_TAIL)
					open_q[o] <= 1'b0;
	end

	for (genvar o = 0; o < NUM_PORTS; o++)
	begin : g_out
		req_vec_t hits;
		for (genvar r = 0; r < NUM_REQS; r++)
		begin : g_r
			assign hits[r] = i_grant[r] && i_req[r][o];
		end

		a_idle_rst: assert property (@(posedge Clk) !Rst |-> i_out[o].kind == FLIT_IDLE)
			else $error("output %0d not idle in reset", o);
		a_no_nest: assert property (@(posedge Clk) disable iff (!Rst)
			!(open_q[o] && i_out[o].kind == FLIT_HEAD))
			else $error("head inside open packet on output %0d", o);
		a_one_grant: assert property (@(posedge Clk) disable iff (!Rst) $onehot0(hits))
			else $error("two grants for output %0d", o);
	end

endmodule

bind mesh_router mesh_router_sva u_sva (
	.Clk     (Clk),
	.Rst     (Rst),
	.i_out   (out_flit),
	.i_req   (req),
	.i_grant (grant)
);

/* mesh_router.sv */
// ####################################################################
// five-port mesh router, two VCs
// input ports, switch allocator and output crossbar
// ####################################################################
`timescale 1ns/100ps

module mesh_router import router_pkg::*; (
	input  logic   Clk,
	input  logic   Rst,
	input  flit_t  i_flit_local,
	input  flit_t  i_flit_north,
	input  flit_t  i_flit_south,
	input  flit_t  i_flit_east,
	input  flit_t  i_flit_west,
	input  vc_t    i_vc_local,
	input  vc_t    i_vc_north,
	input  vc_t    i_vc_south,
	input  vc_t    i_vc_east,
	input  vc_t    i_vc_west,
	input  coord_t i_addr_x,
	input  coord_t i_addr_y,
	output flit_t  o_flit_local,
	output flit_t  o_flit_north,
	output flit_t  o_flit_south,
	output flit_t  o_flit_east,
	output flit_t  o_flit_west,
	output vc_t    o_vc_local,
	output vc_t    o_vc_north,
	output vc_t    o_vc_south,
	output vc_t    o_vc_east,
	output vc_t    o_vc_west
);

	flit_t [NUM_PORTS-1:0]     in_flit;
	vc_t [NUM_PORTS-1:0]       in_vc;
	flit_t [NUM_PORTS-1:0]     out_flit;
	vc_t [NUM_PORTS-1:0]       out_vc;
	flit_t [NUM_REQS-1:0]      heads;   // indexed by requester
	port_vec_t [NUM_REQS-1:0]  req;
	req_vec_t                  tail;
	req_vec_t                  grant;
	req_idx_t [NUM_PORTS-1:0]  sel;
	port_vec_t                 sel_valid;

	assign in_flit[PORT_LOCAL] = i_flit_local;
	assign in_flit[PORT_NORTH] = i_flit_north;
	assign in_flit[PORT_SOUTH] = i_flit_south;
	assign in_flit[PORT_EAST]  = i_flit_east;
	assign in_flit[PORT_WEST]  = i_flit_west;
	assign in_vc[PORT_LOCAL]   = i_vc_local;
	assign in_vc[PORT_NORTH]   = i_vc_north;
	assign in_vc[PORT_SOUTH]   = i_vc_south;
	assign in_vc[PORT_EAST]    = i_vc_east;
	assign in_vc[PORT_WEST]    = i_vc_west;

	assign o_flit_local = out_flit[PORT_LOCAL];
	assign o_flit_north = out_flit[PORT_NORTH];
	assign o_flit_south = out_flit[PORT_SOUTH];
	assign o_flit_east  = out_flit[PORT_EAST];
	assign o_flit_west  = out_flit[PORT_WEST];
	assign o_vc_local   = out_vc[PORT_LOCAL];
	assign o_vc_north   = out_vc[PORT_NORTH];
	assign o_vc_south   = out_vc[PORT_SOUTH];
	assign o_vc_east    = out_vc[PORT_EAST];
	assign o_vc_west    = out_vc[PORT_WEST];

	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_in
		input_port u_in (
			.Clk      (Clk),
			.Rst      (Rst),
			.i_flit   (in_flit[p]),
			.i_vc     (in_vc[p]),
			.i_addr_x (i_addr_x),
			.i_addr_y (i_addr_y),
			.i_grant  (grant[p*NUM_VCS +: NUM_VCS]),
			.o_head   (heads[p*NUM_VCS +: NUM_VCS]),
			.o_req    (req[p*NUM_VCS +: NUM_VCS]),
			.o_tail   (tail[p*NUM_VCS +: NUM_VCS])
		);
	end

	switch_allocator u_alloc (
		.Clk         (Clk),
		.Rst         (Rst),
		.i_req       (req),
		.i_tail      (tail),
		.o_grant     (grant),
		.o_sel       (sel),
		.o_sel_valid (sel_valid)
	);

	output_crossbar u_xbar (
		.Clk         (Clk),
		.Rst         (Rst),
		.i_heads     (heads),
		.i_sel       (sel),
		.i_sel_valid (sel_valid),
		.o_flit      (out_flit),
		.o_vc        (out_vc)
	);

endmodule

/* output_crossbar.sv */
// ####################################################################
// output crossbar
// moves the granted head flit of each output onto its link register
// ####################################################################
`timescale 1ns/100ps

module output_crossbar import router_pkg::*; (
	input  logic                       Clk,
	input  logic                       Rst,
	input  flit_t [NUM_REQS-1:0]       i_heads,
	input  req_idx_t [NUM_PORTS-1:0]   i_sel,
	input  port_vec_t                  i_sel_valid,
	output flit_t [NUM_PORTS-1:0]      o_flit,
	output vc_t [NUM_PORTS-1:0]        o_vc
);

	always_ff @(posedge Clk or negedge Rst)
	begin
		if (!Rst)
		begin
			o_flit <= '0;
			o_vc   <= '0;
		end
		else
		begin
			for (int o = 0; o < NUM_PORTS; o++)
			begin
				if (i_sel_valid[o])
				begin
					o_flit[o] <= i_heads[i_sel[o]];
					o_vc[o]   <= vc_t'(i_sel[o] % NUM_VCS);  // packet keeps its VC
				end
				else
				begin
					o_flit[o] <= IDLE_FLIT;   // nothing on the link
					o_vc[o]   <= '0;
				end
			end
		end
	end

endmodule

/* switch_allocator.sv */
// ####################################################################
// switch allocator
// round-robin arbitration per output, output stays locked to one
// requester from head flit to tail flit
// ####################################################################
`timescale 1ns/100ps

module switch_allocator import router_pkg::*; (
	input  logic                       Clk,
	input  logic                       Rst,
	input  port_vec_t [NUM_REQS-1:0]   i_req,
	input  req_vec_t                   i_tail,
	output req_vec_t                   o_grant,
	output req_idx_t [NUM_PORTS-1:0]   o_sel,
	output port_vec_t                  o_sel_valid
);

	port_vec_t                lock_q;
	req_idx_t [NUM_PORTS-1:0] owner_q;  // requester holding each locked output
	req_idx_t [NUM_PORTS-1:0] ptr_q;    // round-robin start point

	always_comb
	begin
		int idx;
		idx         = 0;
		o_sel       = '0;
		o_sel_valid = '0;
		o_grant     = '0;
		for (int o = 0; o < NUM_PORTS; o++)
		begin
			if (lock_q[o])
			begin
				// only the owner may continue its packet
				if (i_req[owner_q[o]][o])
				begin
					o_sel[o]       = owner_q[o];
					o_sel_valid[o] = 1'b1;
				end
			end
			else
			begin
				// walk backwards so the requester nearest the pointer wins
				for (int k = NUM_REQS - 1; k >= 0; k--)
				begin
					idx = (int'(ptr_q[o]) + k) % NUM_REQS;
					if (i_req[idx][o])
					begin
						o_sel[o]       = req_idx_t'(idx);
						o_sel_valid[o] = 1'b1;
					end
				end
			end
			if (o_sel_valid[o])
				o_grant[o_sel[o]] = 1'b1;  // requests are one-hot, so no clash
		end
	end

	always_ff @(posedge Clk or negedge Rst)
	begin
		if (!Rst)
		begin
			lock_q  <= '0;
			owner_q <= '0;
			ptr_q   <= '0;
		end
		else
		begin
			for (int o = 0; o < NUM_PORTS; o++)
			begin
				if (o_sel_valid[o])
				begin
					lock_q[o]  <= !i_tail[o_sel[o]];   // tail frees the output
					owner_q[o] <= o_sel[o];
					if (!lock_q[o])
						ptr_q[o] <= (o_sel[o] == req_idx_t'(NUM_REQS - 1)) ?
							'0 : o_sel[o] + 1'b1;
				end
			end
		end
	end

endmodule

/* input_port.sv */
// ####################################################################
// router input port
// steers flits into per-VC FIFOs, XY-routes head flits and keeps
// the route of each packet until its tail leaves
// ####################################################################
`timescale 1ns/100ps

module input_port import router_pkg::*; (
	input  logic                      Clk,
	input  logic                      Rst,
	input  flit_t                     i_flit,
	input  vc_t                       i_vc,
	input  coord_t                    i_addr_x,
	input  coord_t                    i_addr_y,
	input  logic [NUM_VCS-1:0]        i_grant,
	output flit_t [NUM_VCS-1:0]       o_head,
	output port_vec_t [NUM_VCS-1:0]   o_req,
	output logic [NUM_VCS-1:0]        o_tail
);

	logic [NUM_VCS-1:0] wr_q;        // write strobe per VC
	flit_t              data_q;
	logic [NUM_VCS-1:0] fifo_empty;
	logic [NUM_VCS-1:0] fifo_full;

	// dimension order resolves x first and then y
	function automatic port_vec_t xy_route(flit_t f, coord_t x, coord_t y);
		port_vec_t r;
		r = '0;
		if (f.dst_x > x)
			r[PORT_EAST] = 1'b1;
		else if (f.dst_x < x)
			r[PORT_WEST] = 1'b1;
		else if (f.dst_y > y)
			r[PORT_NORTH] = 1'b1;
		else if (f.dst_y < y)
			r[PORT_SOUTH] = 1'b1;
		else
			r[PORT_LOCAL] = 1'b1;   // arrived, eject here
		return r;
	endfunction

	always_ff @(posedge Clk or negedge Rst)
	begin
		if (!Rst)
			wr_q <= '0;
		else
		begin
			wr_q <= '0;
			if (i_flit.kind != FLIT_IDLE && !fifo_full[i_vc])
				wr_q[i_vc] <= 1'b1;
		end
	end

	always_ff @(posedge Clk)
	begin
		data_q <= i_flit;
	end

	for (genvar v = 0; v < NUM_VCS; v++)
	begin : g_vc
		port_vec_t route_q;     // output owned by the packet in flight
		port_vec_t cur_route;

		flit_fifo u_fifo (
			.Clk     (Clk),
			.Rst     (Rst),
			.i_wr    (wr_q[v]),
			.i_data  (data_q),
			.i_rd    (i_grant[v]),
			.o_data  (o_head[v]),
			.o_empty (fifo_empty[v]),
			.o_full  (fifo_full[v])
		);

		// a head flit routes itself, body and tail follow the held route
		assign cur_route = (o_head[v].kind == FLIT_HEAD) ?
			xy_route(o_head[v], i_addr_x, i_addr_y) : route_q;
		assign o_req[v]  = fifo_empty[v] ? '0 : cur_route;
		assign o_tail[v] = !fifo_empty[v] && (o_head[v].kind == FLIT_TAIL);

		always_ff @(posedge Clk or negedge Rst)
		begin
			if (!Rst)
				route_q <= '0;
			else if (i_grant[v])
				route_q <= o_tail[v] ? '0 : cur_route;  // tail releases the route
		end
	end

endmodule

/* flit_fifo.sv */
// ####################################################################
// flit FIFO for one virtual channel
// circular buffer, head flit visible on o_data before it is read
// ####################################################################
`timescale 1ns/100ps

module flit_fifo import router_pkg::*; (
	input  logic  Clk,
	input  logic  Rst,
	input  logic  i_wr,
	input  flit_t i_data,
	input  logic  i_rd,
	output flit_t o_data,
	output logic  o_empty,
	output logic  o_full
);

	flit_t              mem [BUFF_DEPTH];
	logic [BUFF_AW-1:0] wr_ptr;
	logic [BUFF_AW-1:0] rd_ptr;
	logic [BUFF_AW:0]   count;   // one extra bit to tell full from empty
	logic               do_wr;
	logic               do_rd;

	assign o_empty = (count == '0);
	assign o_full  = (count == (BUFF_AW+1)'(BUFF_DEPTH));
	assign do_wr   = i_wr && !o_full;   // overflow flit is lost
	assign do_rd   = i_rd && !o_empty;
	assign o_data  = mem[rd_ptr];

	always_ff @(posedge Clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= i_data;
	end

	always_ff @(posedge Clk or negedge Rst)
	begin
		if (!Rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;  // wraps by itself at a power-of-two depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* router_pkg.sv */
// ####################################################################
// mesh router shared definitions
// flit layout, port and VC numbering, buffer sizing for a 3x3 mesh
// ####################################################################
package router_pkg;

	localparam int FLIT_W  = 12;
	localparam int COORD_W = 3;    // enough for the mesh size
	localparam int KIND_W  = 2;
	localparam int PAYLD_W = FLIT_W - 2 * COORD_W - KIND_W;

	typedef logic [COORD_W-1:0] coord_t;

	// flit type codes where idle means nothing on the link
	typedef enum logic [KIND_W-1:0] {
		FLIT_IDLE = 2'b00,
		FLIT_BODY = 2'b01,
		FLIT_HEAD = 2'b10,
		FLIT_TAIL = 2'b11
	} flit_kind_t;

	typedef struct packed {
		logic [PAYLD_W-1:0] payload;  // bits 11:8
		coord_t             dst_x;    // bits 7:5
		coord_t             dst_y;    // bits 4:2
		flit_kind_t         kind;     // bits 1:0
	} flit_t;

	localparam flit_t IDLE_FLIT = '0;

	localparam int NUM_PORTS  = 5;
	localparam int PORT_LOCAL = 0;
	localparam int PORT_NORTH = 1;
	localparam int PORT_SOUTH = 2;
	localparam int PORT_EAST  = 3;
	localparam int PORT_WEST  = 4;

	typedef logic [NUM_PORTS-1:0] port_vec_t;  // one bit per port

	localparam int NUM_VCS = 2;
	typedef logic [$clog2(NUM_VCS)-1:0] vc_t;

	// requester = port * NUM_VCS + vc
	localparam int NUM_REQS = NUM_PORTS * NUM_VCS;
	localparam int REQ_IW   = $clog2(NUM_REQS);
	typedef logic [NUM_REQS-1:0] req_vec_t;
	typedef logic [REQ_IW-1:0]   req_idx_t;

	localparam int BUFF_DEPTH = 8;
	localparam int BUFF_AW    = 3;

endpackage
